// File: include/rvc_config.svh
// fixed widths, register numbers and encodings for the RVC expander
// include wherever a width or a fixed field is needed
`ifndef RVC_CONFIG_SVH
`define RVC_CONFIG_SVH

// instruction widths
`define RVC_INSTR_W 32
`define RVC_HALF_W 16

// fixed architectural registers
`define RVC_REG_SP 5'd2
`define RVC_REG_RA 5'd1

// upper bits that place a 3-bit register field at x8..x15
`define RVC_CREG_PREFIX 2'b01

// ebreak, fully encoded
`define RVC_EBREAK 32'h0010_0073

`endif

// File: verilog/rvc_pkg.sv
// types shared by the RVC expanders and the decode register
// referenced with scoped names from each user
`include "rvc_config.svh"

package rvc_pkg;

  ////////////////////
  // opcodes
  ////////////////////

  // RV32 major opcodes, the low seven bits of every expanded word
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } rvc_opcode_e;

  // low two instruction bits, 11 marks a full-width word
  typedef enum logic [1:0] {
    C0   = 2'b00,
    C1   = 2'b01,
    C2   = 2'b10,
    FULL = 2'b11
  } rvc_quadrant_e;

  ////////////////////
  // results
  ////////////////////

  // one expander's output
  typedef struct packed {
    logic [`RVC_INSTR_W-1:0] instr;
    logic                    illegal;
  } rvc_result_t;

  // registered decode result
  typedef struct packed {
    logic [`RVC_INSTR_W-1:0] instr;
    logic                    is_compressed;
    logic                    illegal;
  } rvc_decoded_t;

endpackage

// File: verilog/rvc_c0_expand.sv
// quadrant 0 expansion: stack-relative add, word load and word store
`timescale 1ns/10ps
`include "rvc_config.svh"

module rvc_c0_expand (
  input  logic [`RVC_HALF_W-1:0] instr_i,
  output rvc_pkg::rvc_result_t   result_o
);

  // prime registers, x8..x15
  logic [4:0] rd_p;
  logic [4:0] rs1_p;

  assign rd_p  = {`RVC_CREG_PREFIX, instr_i[4:2]};
  assign rs1_p = {`RVC_CREG_PREFIX, instr_i[9:7]};

  always_comb begin
    result_o.instr   = '0;
    result_o.illegal = 1'b0;

    unique case (instr_i[15:13])
      3'b000: begin
        // c.addi4spn -> addi rd', sp, nzuimm
        result_o.instr = {2'b00, instr_i[10:7], instr_i[12:11], instr_i[5], instr_i[6],
                          2'b00, `RVC_REG_SP, 3'b000, rd_p, rvc_pkg::OPC_OP_IMM};
        // all-zero immediate is reserved
        result_o.illegal = (instr_i[12:5] == 8'b0);
      end
      3'b010: begin
        // c.lw -> lw rd', uimm(rs1')
        result_o.instr = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00,
                          rs1_p, 3'b010, rd_p, rvc_pkg::OPC_LOAD};
      end
      3'b110: begin
        // c.sw -> sw rs2', uimm(rs1'), rs2' sits where rd' is
        result_o.instr = {5'b0, instr_i[5], instr_i[12], rd_p, rs1_p, 3'b010,
                          instr_i[11:10], instr_i[6], 2'b00, rvc_pkg::OPC_STORE};
      end
      default: begin
        // float load/store and the Zc slots
        result_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

// File: verilog/rvc_c1_expand.sv
// quadrant 1 expansion: immediates, shifts, register ALU ops, jumps and branches
`timescale 1ns/10ps
`include "rvc_config.svh"

module rvc_c1_expand (
  input  logic [`RVC_HALF_W-1:0] instr_i,
  output rvc_pkg::rvc_result_t   result_o
);

  logic [4:0]  rd;
  logic [4:0]  rs1_p;
  logic [4:0]  rs2_p;
  logic [11:0] imm6_sext;
  logic [4:0]  jal_rd;

  // full register field, used by addi/li/lui
  assign rd    = instr_i[11:7];
  // prime fields for the ALU group and branches
  assign rs1_p = {`RVC_CREG_PREFIX, instr_i[9:7]};
  assign rs2_p = {`RVC_CREG_PREFIX, instr_i[4:2]};

  // 6-bit signed immediate, bit 12 is the sign
  assign imm6_sext = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2]};

  // c.jal links to ra, c.j discards
  assign jal_rd = instr_i[15] ? 5'd0 : `RVC_REG_RA;

  always_comb begin
    result_o.instr   = '0;
    result_o.illegal = 1'b0;

    unique case (instr_i[15:13])
      ////////////////////
      // immediates
      ////////////////////
      3'b000: begin
        // c.addi, rd = 0 is c.nop
        result_o.instr = {imm6_sext, rd, 3'b000, rd, rvc_pkg::OPC_OP_IMM};
      end
      3'b010: begin
        // c.li -> addi rd, x0, imm, rd = 0 is a hint
        result_o.instr = {imm6_sext, 5'd0, 3'b000, rd, rvc_pkg::OPC_OP_IMM};
      end
      3'b011: begin
        if (rd == `RVC_REG_SP) begin
          // c.addi16sp -> addi sp, sp, nzimm*16
          result_o.instr = {{3{instr_i[12]}}, instr_i[4:3], instr_i[5], instr_i[2],
                            instr_i[6], 4'b0, `RVC_REG_SP, 3'b000, `RVC_REG_SP,
                            rvc_pkg::OPC_OP_IMM};
        end else begin
          // c.lui -> lui rd, nzimm
          result_o.instr = {{15{instr_i[12]}}, instr_i[6:2], rd, rvc_pkg::OPC_LUI};
        end
        // zero immediate is reserved for both forms
        result_o.illegal = ({instr_i[12], instr_i[6:2]} == 6'b0);
      end

      ////////////////////
      // shifts and ALU
      ////////////////////
      3'b100: begin
        unique case (instr_i[11:10])
          2'b00, 2'b01: begin
            // c.srli / c.srai, bit 10 picks arithmetic
            result_o.instr = {1'b0, instr_i[10], 5'b0, instr_i[6:2], rs1_p, 3'b101,
                              rs1_p, rvc_pkg::OPC_OP_IMM};
            // shamt[5] only exists on RV64
            result_o.illegal = instr_i[12];
          end
          2'b10: begin
            // c.andi
            result_o.instr = {imm6_sext, rs1_p, 3'b111, rs1_p, rvc_pkg::OPC_OP_IMM};
          end
          default: begin
            unique case ({instr_i[12], instr_i[6:5]})
              3'b000: begin
                // c.sub
                result_o.instr = {7'b0100000, rs2_p, rs1_p, 3'b000, rs1_p, rvc_pkg::OPC_OP};
              end
              3'b001: begin
                // c.xor
                result_o.instr = {7'b0, rs2_p, rs1_p, 3'b100, rs1_p, rvc_pkg::OPC_OP};
              end
              3'b010: begin
                // c.or
                result_o.instr = {7'b0, rs2_p, rs1_p, 3'b110, rs1_p, rvc_pkg::OPC_OP};
              end
              3'b011: begin
                // c.and
                result_o.instr = {7'b0, rs2_p, rs1_p, 3'b111, rs1_p, rvc_pkg::OPC_OP};
              end
              default: begin
                // c.subw, c.addw, c.mul and the unary Zc ops
                result_o.illegal = 1'b1;
              end
            endcase
          end
        endcase
      end

      ////////////////////
      // control flow
      ////////////////////
      3'b001, 3'b101: begin
        // c.jal / c.j, offset bits come back in jal order
        result_o.instr = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6], instr_i[7],
                          instr_i[2], instr_i[11], instr_i[5:3], {9{instr_i[12]}},
                          jal_rd, rvc_pkg::OPC_JAL};
      end
      default: begin
        // c.beqz / c.bnez, bit 13 becomes funct3[0]
        result_o.instr = {{4{instr_i[12]}}, instr_i[6:5], instr_i[2], 5'd0, rs1_p,
                          2'b00, instr_i[13], instr_i[11:10], instr_i[4:3], instr_i[12],
                          rvc_pkg::OPC_BRANCH};
      end
    endcase
  end

endmodule

// File: verilog/rvc_c2_expand.sv
// quadrant 2 expansion: slli, stack-pointer load/store, jr/jalr/mv/add/ebreak
`timescale 1ns/10ps
`include "rvc_config.svh"

module rvc_c2_expand (
  input  logic [`RVC_HALF_W-1:0] instr_i,
  output rvc_pkg::rvc_result_t   result_o
);

  logic [4:0] rd_rs1;
  logic [4:0] rs2;

  assign rd_rs1 = instr_i[11:7];
  assign rs2    = instr_i[6:2];

  always_comb begin
    result_o.instr   = '0;
    result_o.illegal = 1'b0;

    unique case (instr_i[15:13])
      3'b000: begin
        // c.slli, zero shamt or rd = 0 are hints
        result_o.instr   = {7'b0, rs2, rd_rs1, 3'b001, rd_rs1, rvc_pkg::OPC_OP_IMM};
        result_o.illegal = instr_i[12];
      end
      3'b010: begin
        // c.lwsp -> lw rd, uimm(sp)
        result_o.instr = {4'b0, instr_i[3:2], instr_i[12], instr_i[6:4], 2'b00,
                          `RVC_REG_SP, 3'b010, rd_rs1, rvc_pkg::OPC_LOAD};
        // loading into x0 is reserved
        result_o.illegal = (rd_rs1 == 5'd0);
      end
      3'b110: begin
        // c.swsp -> sw rs2, uimm(sp)
        result_o.instr = {4'b0, instr_i[8:7], instr_i[12], rs2, `RVC_REG_SP, 3'b010,
                          instr_i[11:9], 2'b00, rvc_pkg::OPC_STORE};
      end

      ////////////////////
      // register moves and jumps
      ////////////////////
      3'b100: begin
        if (!instr_i[12]) begin
          if (rs2 == 5'd0) begin
            // c.jr -> jalr x0, 0(rs1)
            result_o.instr   = {12'b0, rd_rs1, 3'b000, 5'd0, rvc_pkg::OPC_JALR};
            // no jump through x0
            result_o.illegal = (rd_rs1 == 5'd0);
          end else begin
            // c.mv -> add rd, x0, rs2
            result_o.instr = {7'b0, rs2, 5'd0, 3'b000, rd_rs1, rvc_pkg::OPC_OP};
          end
        end else begin
          if (rs2 == 5'd0) begin
            if (rd_rs1 == 5'd0) begin
              // c.ebreak
              result_o.instr = `RVC_EBREAK;
            end else begin
              // c.jalr -> jalr ra, 0(rs1)
              result_o.instr = {12'b0, rd_rs1, 3'b000, `RVC_REG_RA, rvc_pkg::OPC_JALR};
            end
          end else begin
            // c.add -> add rd, rd, rs2
            result_o.instr = {7'b0, rs2, rd_rs1, 3'b000, rd_rs1, rvc_pkg::OPC_OP};
          end
        end
      end
      default: begin
        // float stack ops and Zc slots
        result_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

// File: verilog/rvc_decode_reg.sv
// picks the expander result by quadrant and registers it with a valid flag
// one cycle from strobe to result, no back-pressure
`timescale 1ns/10ps
`include "rvc_config.svh"

module rvc_decode_reg (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     instr_valid_i,
  input  logic [`RVC_INSTR_W-1:0]  instr_i,
  input  rvc_pkg::rvc_result_t     c0_i,
  input  rvc_pkg::rvc_result_t     c1_i,
  input  rvc_pkg::rvc_result_t     c2_i,
  output rvc_pkg::rvc_decoded_t    decoded_o,
  output logic                     decoded_valid_o
);

  rvc_pkg::rvc_quadrant_e quad;
  rvc_pkg::rvc_decoded_t  pick;
  rvc_pkg::rvc_decoded_t  decoded_q;
  logic                   valid_q;

  assign quad = rvc_pkg::rvc_quadrant_e'(instr_i[1:0]);

  ////////////////////
  // quadrant select
  ////////////////////
  always_comb begin
    pick.is_compressed = 1'b1;
    unique case (quad)
      rvc_pkg::C0: {pick.instr, pick.illegal} = c0_i;
      rvc_pkg::C1: {pick.instr, pick.illegal} = c1_i;
      rvc_pkg::C2: {pick.instr, pick.illegal} = c2_i;
      default: begin
        // full-width word goes through untouched
        pick.instr         = instr_i;
        pick.is_compressed = 1'b0;
        pick.illegal       = 1'b0;
      end
    endcase
  end

  ////////////////////
  // output register
  ////////////////////
  // payload only loads on a strobe and holds otherwise
  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      decoded_q <= pick;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= instr_valid_i;
    end
  end

  assign decoded_o       = decoded_q;
  assign decoded_valid_o = valid_q;

endmodule

// File: verilog/rvc_decoder.sv
// top level RVC decoder: three quadrant expanders feeding one output register
// drive one instruction per strobe, collect the result one cycle later
`timescale 1ns/10ps
`include "rvc_config.svh"

module rvc_decoder (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    instr_valid_i,
  input  logic [`RVC_INSTR_W-1:0] instr_i,
  output logic                    decoded_valid_o,
  output logic [`RVC_INSTR_W-1:0] decoded_instr_o,
  output logic                    is_compressed_o,
  output logic                    illegal_instr_o
);

  rvc_pkg::rvc_result_t  c0_res;
  rvc_pkg::rvc_result_t  c1_res;
  rvc_pkg::rvc_result_t  c2_res;
  rvc_pkg::rvc_decoded_t decoded;

  // every expander sees the low half, the register picks one
  rvc_c0_expand c0_expand_inst (
    .instr_i  (instr_i[`RVC_HALF_W-1:0]),
    .result_o (c0_res)
  );

  rvc_c1_expand c1_expand_inst (
    .instr_i  (instr_i[`RVC_HALF_W-1:0]),
    .result_o (c1_res)
  );

  rvc_c2_expand c2_expand_inst (
    .instr_i  (instr_i[`RVC_HALF_W-1:0]),
    .result_o (c2_res)
  );

  rvc_decode_reg decode_reg_inst (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .instr_valid_i   (instr_valid_i),
    .instr_i         (instr_i),
    .c0_i            (c0_res),
    .c1_i            (c1_res),
    .c2_i            (c2_res),
    .decoded_o       (decoded),
    .decoded_valid_o (decoded_valid_o)
  );

  // flatten the registered struct onto the ports
  assign decoded_instr_o = decoded.instr;
  assign is_compressed_o = decoded.is_compressed;
  assign illegal_instr_o = decoded.illegal;

endmodule

// File: tests/tb_clk_gen.sv
// clock and reset source for the decoder testbench
// 8 ns clock, reset held low for 16 cycles and let go on a falling edge
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD = 4;
  localparam int RST_CYCLES  = 16;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // synchronous reset, released away from the rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// File: tests/rvc_decoder_checker.sv
// port-level protocol checks bound into every rvc_decoder instance
`timescale 1ns/10ps
`include "rvc_config.svh"

module rvc_decoder_checker (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input logic                    instr_valid_i,
  input logic                    decoded_valid_i,
  input logic [`RVC_INSTR_W-1:0] decoded_instr_i,
  input logic                    illegal_instr_i
);

  // number of assertion failures so far
  int unsigned fail_count = 0;

  // quiet while reset is held and on the first edge after it
  reset_quiet: assert property (@(posedge clk_i) !rst_n_i |=> !decoded_valid_i)
    else begin
      fail_count++;
      $error("decoded valid high during or right after reset");
    end

  // output valid is the input strobe delayed by one cycle
  strobe_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    1'b1 |=> (decoded_valid_i == $past(instr_valid_i)))
    else begin
      fail_count++;
      $error("decoded valid does not follow the input strobe by one cycle");
    end

  // every legal expansion is a full-width word
  full_width_out: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (decoded_valid_i && !illegal_instr_i) |-> (decoded_instr_i[1:0] == 2'b11))
    else begin
      fail_count++;
      $error("legal decoded word without low bits 11");
    end

endmodule

bind rvc_decoder rvc_decoder_checker rvc_decoder_checker_inst (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .instr_valid_i   (instr_valid_i),
  .decoded_valid_i (decoded_valid_o),
  .decoded_instr_i (decoded_instr_o),
  .illegal_instr_i (illegal_instr_o)
);

// File: tests/tb_rvc_decoder.sv
// trace-driven testbench for the RVC decoder
// drives one trace line per falling edge and checks each result one cycle later
`timescale 1ns/10ps
`include "rvc_config.svh"

module tb_rvc_decoder;

  // one line of the trace file
  typedef struct packed {
    logic                    valid;
    logic [`RVC_INSTR_W-1:0] instr;
    logic [`RVC_INSTR_W-1:0] exp_instr;
    logic                    exp_comp;
    logic                    exp_illegal;
  } trace_line_t;

  logic                    clk;
  logic                    rst_n;
  logic                    instr_valid;
  logic [`RVC_INSTR_W-1:0] instr;
  logic                    decoded_valid;
  logic [`RVC_INSTR_W-1:0] decoded_instr;
  logic                    is_compressed;
  logic                    illegal_instr;

  trace_line_t trace_q[$];
  // results still owed by the DUT with the oldest at the front
  trace_line_t expect_q[$];
  logic        rst_seen = 1'b0;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  tb_clk_gen clk_gen_inst (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  rvc_decoder rvc_decoder_inst (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .instr_valid_i   (instr_valid),
    .instr_i         (instr),
    .decoded_valid_o (decoded_valid),
    .decoded_instr_o (decoded_instr),
    .is_compressed_o (is_compressed),
    .illegal_instr_o (illegal_instr)
  );

  task automatic stop_with_failure();
    $display("test failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  ////////////////////
  // trace input
  ////////////////////
  // lines that do not parse as five hex fields are comments
  task automatic load_trace();
    int          fd;
    int          fields;
    string       text;
    trace_line_t entry;
    logic [31:0] f_valid, f_instr, f_exp, f_comp, f_ill;
    fd = $fopen("tests/rvc_trace.txt", "r");
    assert (fd != 0) else begin
      $display("error: cannot open the trace file tests/rvc_trace.txt");
      stop_with_failure();
    end
    while (!$feof(fd)) begin
      if ($fgets(text, fd) > 0) begin
        fields = $sscanf(text, "%h %h %h %h %h", f_valid, f_instr, f_exp, f_comp, f_ill);
        if (fields == 5) begin
          entry.valid       = f_valid[0];
          entry.instr       = f_instr;
          entry.exp_instr   = f_exp;
          entry.exp_comp    = f_comp[0];
          entry.exp_illegal = f_ill[0];
          trace_q.push_back(entry);
        end
      end
    end
    $fclose(fd);
  endtask

  ////////////////////
  // output checks
  ////////////////////
  task automatic check_output();
    trace_line_t want;
    // protocol assertions of the bound checker
    assert (rvc_decoder_inst.rvc_decoder_checker_inst.fail_count == 0) else begin
      $display("error at %0t: a protocol assertion in the bound checker failed", $time);
      stop_with_failure();
    end
    if (decoded_valid === 1'b1) begin
      assert (expect_q.size() != 0) else begin
        $display("error at %0t: decoded valid with no instruction outstanding", $time);
        stop_with_failure();
      end
      want = expect_q.pop_front();
      assert (is_compressed === want.exp_comp) else begin
        $display("mismatch at %0t: input %h compressed flag %b, expected %b",
                 $time, want.instr, is_compressed, want.exp_comp);
        stop_with_failure();
      end
      assert (illegal_instr === want.exp_illegal) else begin
        $display("mismatch at %0t: input %h illegal flag %b, expected %b",
                 $time, want.instr, illegal_instr, want.exp_illegal);
        stop_with_failure();
      end
      // expansion of an illegal encoding is unspecified
      if (!want.exp_illegal) begin
        assert (decoded_instr === want.exp_instr) else begin
          $display("mismatch at %0t: input %h expanded to %h, expected %h",
                   $time, want.instr, decoded_instr, want.exp_instr);
          stop_with_failure();
        end
      end
    end else begin
      // with one cycle of latency a pending entry here means a dropped result
      assert (expect_q.size() == 0) else begin
        $display("error at %0t: no decoded output for input %h", $time, expect_q[0].instr);
        stop_with_failure();
      end
    end
  endtask

  // reset level seen at the last rising edge for use on falling edges
  always @(posedge clk) begin
    rst_seen <= rst_n;
  end

  // cycle budget that is armed once the trace length is known
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("error: run did not finish within %0d cycles", cycle_limit);
      stop_with_failure();
    end
  end

  ////////////////////
  // stimulus
  ////////////////////
  initial begin
    trace_line_t entry;
    instr_valid = 1'b0;
    instr       = '0;
    load_trace();
    assert (trace_q.size() > 0) else begin
      $display("error: the trace file holds no test lines");
      stop_with_failure();
    end
    // reset plus two cycles per line plus margin
    cycle_limit = 16 + 2 * trace_q.size() + 20;

    while (trace_q.size() != 0) begin
      @(negedge clk);
      check_output();
      if (rst_seen) begin
        entry       = trace_q.pop_front();
        instr_valid = entry.valid;
        instr       = entry.instr;
        if (entry.valid) begin
          expect_q.push_back(entry);
        end
      end
    end

    // collect the last result and make sure valid drops
    @(negedge clk);
    check_output();
    instr_valid = 1'b0;
    @(negedge clk);
    check_output();

    $display("test passed");
    $finish;
  end

endmodule

// File: tests/rvc_trace.txt
# columns: valid, input word, expected word, compressed flag, illegal flag (hex)
# expected word is ignored on illegal lines and on lines with valid 0
1 003100b3 003100b3 0 0
1 123452b7 123452b7 0 0
1 000001a4 0c810493 1 0
1 00000000 00000000 1 1
1 000041e8 0445a503 1 0
1 0000c690 00c6a423 1 0
1 00002000 00000000 1 1
1 00008000 00000000 1 1
0 00000000 00000000 0 0
1 000012f5 ffd28293 1 0
1 00004345 01100313 1 0
1 000073fd fffff3b7 1 0
1 00006381 00000000 1 1
1 0000713d fe010113 1 0
1 0000800d 00345413 1 0
1 00008495 4054d493 1 0
1 0000900d 00000000 1 1
1 0000997d fff57513 1 0
1 00008c05 40940433 1 0
1 00008db1 00c5c5b3 1 0
1 00008ed9 00e6e6b3 1 0
1 00008fe1 0087f7b3 1 0
1 00009c05 00000000 1 1
1 00009c25 00000000 1 1
1 00009c45 00000000 1 1
1 00002801 010000ef 1 0
1 0000aa91 1540006f 1 0
1 0000c401 00040463 1 0
1 0000fcf5 fe049ee3 1 0
0 00000000 00000000 0 0
0 00000000 00000000 0 0
1 0000029e 00729293 1 0
1 0000537e 0fc12303 1 0
1 00004032 00000000 1 1
1 0000c81e 00712823 1 0
1 00008082 00008067 1 0
1 00008002 00000000 1 1
1 0000852e 00b00533 1 0
1 00009282 000280e7 1 0
1 00009426 00940433 1 0
1 00009002 00100073 1 0
1 dead0001 00000013 1 0

// File: filelist.f
+incdir+include
verilog/rvc_pkg.sv
verilog/rvc_c0_expand.sv
verilog/rvc_c1_expand.sv
verilog/rvc_c2_expand.sv
verilog/rvc_decode_reg.sv
verilog/rvc_decoder.sv
tests/tb_clk_gen.sv
tests/rvc_decoder_checker.sv
tests/tb_rvc_decoder.sv

// File: Bender.yml
package:
  name: rvc_decoder

export_include_dirs:
  - include

sources:
  - verilog/rvc_pkg.sv
  - verilog/rvc_c0_expand.sv
  - verilog/rvc_c1_expand.sv
  - verilog/rvc_c2_expand.sv
  - verilog/rvc_decode_reg.sv
  - verilog/rvc_decoder.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/rvc_decoder_checker.sv
      - tests/tb_rvc_decoder.sv
